//--- verilog/vec_pkg.sv
/* Widths, types and encodings shared by the vector coprocessor and its testbench.
   Elements are fixed at 32 bits and vl_t holds at most 255, so VLEN/32 must stay below 256. */

package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  typedef logic [ElemWidth-1:0]         elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_idx_t;
  // Vector length or element index
  typedef logic [7:0]                   vl_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Host opcodes, codes 9 to 15 are rejected
  typedef enum logic [3:0] {
    OP_SETVL   = 4'd0,
    OP_VADD_VV = 4'd1,
    OP_VSUB_VV = 4'd2,
    OP_VAND_VV = 4'd3,
    OP_VXOR_VV = 4'd4,
    OP_VADD_VX = 4'd5,
    OP_VMV_VX  = 4'd6,
    OP_REDSUM  = 4'd7,
    OP_EXTRACT = 4'd8
  } vec_op_e;

  // Lane ALU ops, vs2 is the first operand
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_XOR  = 3'd3,
    ALU_ADDX = 3'd4,
    ALU_MOVX = 3'd5,
    ALU_NONE = 3'd6
  } alu_op_e;

endpackage

//--- verilog/vec_dispatcher.sv
/* Decode stage. One command in flight; ack stays high and the response frozen
   until the host drops req. Illegal opcodes report an error and change no state. */

module vec_dispatcher import vec_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned VLEN    = 256
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host side
  input  logic      cmd_req_i,
  input  vec_op_e   cmd_op_i,
  input  vreg_idx_t cmd_vd_i,
  input  vreg_idx_t cmd_vs1_i,
  input  vreg_idx_t cmd_vs2_i,
  input  elem_t     cmd_scalar_i,
  output logic      cmd_ack_o,
  output elem_t     resp_data_o,
  output logic      resp_err_o,
  // Execute side
  output logic      start_o,
  output alu_op_e   alu_op_o,
  output vreg_idx_t vd_o,
  output vreg_idx_t vs1_o,
  output vreg_idx_t vs2_o,
  output elem_t     scalar_o,
  output elem_t     acc_init_o,
  output vl_t       vl_o,
  output logic      is_extract_o,
  input  logic      done_i,
  input  elem_t     acc_i
);

  localparam int unsigned VLMAX        = VLEN / ElemWidth;
  localparam int unsigned GroupsPerReg = VLMAX / NrLanes;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT, ACK} state_e;

  state_e    state_q;
  logic      ack_q;
  logic      err_q;
  vl_t       vl_q;
  elem_t     resp_q;
  // Latched command
  vec_op_e   op_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  elem_t     scalar_q;

  logic      legal;
  logic      is_setvl;
  logic      use_acc;
  alu_op_e   alu_op;
  vl_t       new_vl;

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    legal    = 1'b1;
    is_setvl = 1'b0;
    use_acc  = 1'b0;
    alu_op   = ALU_NONE;
    case (op_q)
      OP_SETVL:   is_setvl = 1'b1;
      OP_VADD_VV: alu_op = ALU_ADD;
      OP_VSUB_VV: alu_op = ALU_SUB;
      OP_VAND_VV: alu_op = ALU_AND;
      OP_VXOR_VV: alu_op = ALU_XOR;
      OP_VADD_VX: alu_op = ALU_ADDX;
      OP_VMV_VX:  alu_op = ALU_MOVX;
      OP_REDSUM,
      OP_EXTRACT: use_acc = 1'b1;
      default:    legal = 1'b0;
    endcase
  end

  // Requested length clamped to VLMAX
  assign new_vl = (scalar_q > VLMAX) ? vl_t'(VLMAX) : vl_t'(scalar_q);

  assign start_o      = (state_q == ISSUE) && legal && !is_setvl;
  assign alu_op_o     = alu_op;
  assign vd_o         = vd_q;
  assign vs1_o        = vs1_q;
  assign vs2_o        = vs2_q;
  assign scalar_o     = scalar_q;
  assign acc_init_o   = (op_q == OP_REDSUM) ? scalar_q : '0;
  assign vl_o         = vl_q;
  assign is_extract_o = (op_q == OP_EXTRACT);
  assign cmd_ack_o    = ack_q;
  assign resp_err_o   = err_q;
  assign resp_data_o  = resp_q;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      vl_q    <= '0;
    end else begin
      case (state_q)
        IDLE: if (cmd_req_i) state_q <= ISSUE;
        ISSUE: begin
          err_q <= !legal;
          if (!legal || is_setvl) begin
            ack_q   <= 1'b1;
            state_q <= ACK;
          end else begin
            state_q <= WAIT;
          end
          if (legal && is_setvl) vl_q <= new_vl;
        end
        WAIT: begin
          if (done_i) begin
            ack_q   <= 1'b1;
            state_q <= ACK;
          end
        end
        ACK: begin
          if (!cmd_req_i) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command capture and response
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cmd_req_i) begin
      op_q     <= cmd_op_i;
      vd_q     <= cmd_vd_i;
      vs1_q    <= cmd_vs1_i;
      vs2_q    <= cmd_vs2_i;
      scalar_q <= cmd_scalar_i;
    end
    if (state_q == ISSUE) resp_q <= (legal && is_setvl) ? elem_t'(new_vl) : '0;
    if (state_q == WAIT && done_i) resp_q <= use_acc ? acc_i : '0;
  end

  ack_only_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cmd_ack_o) |-> cmd_req_i);

  // Execute never takes more than one full register sweep
  done_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_o |-> ##[1:GroupsPerReg] done_i);

endmodule

//--- verilog/vec_sequencer.sv
/* Execute control. Walks element groups from 0, one group per cycle.
   A zero vl still runs one empty group; an extract runs only its own group. */

module vec_sequencer import vec_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned VLEN    = 256,
  localparam int unsigned VLMAX        = VLEN / ElemWidth,
  localparam int unsigned GroupsPerReg = VLMAX / NrLanes,
  localparam int unsigned GrpW         = (GroupsPerReg > 1) ? $clog2(GroupsPerReg) : 1
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  vl_t                vl_i,
  input  logic               is_extract_i,
  input  elem_t              scalar_i,
  output logic               grp_valid_o,
  output logic [GrpW-1:0]    grp_idx_o,
  output logic [NrLanes-1:0] elem_en_o,
  output logic               acc_clear_o,
  output logic               done_o
);

  localparam int unsigned LaneW = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  logic             active_q;
  logic [GrpW-1:0]  grp_q;
  logic [GrpW-1:0]  last_q;
  logic             extract_q;
  logic             ext_hit_q;
  logic [LaneW-1:0] ext_lane_q;
  vl_t              vl_q;

  int unsigned      n_grp;
  logic             ext_hit;
  logic [GrpW-1:0]  ext_grp;
  logic [GrpW-1:0]  first_grp;
  logic [GrpW-1:0]  last_grp;

  // Group count is at least one
  assign n_grp = (vl_i == '0) ? 1 : (int'(vl_i) + NrLanes - 1) / NrLanes;

  // Extract index out of range enables no lane
  assign ext_hit   = scalar_i < VLMAX;
  assign ext_grp   = ext_hit ? GrpW'(scalar_i / NrLanes) : '0;
  assign first_grp = is_extract_i ? ext_grp : '0;
  assign last_grp  = is_extract_i ? ext_grp : GrpW'(n_grp - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      grp_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      grp_q    <= first_grp;
    end else if (done_o) begin
      active_q <= 1'b0;
    end else if (active_q) begin
      grp_q <= grp_q + 1'b1;
    end
  end

  // Per-command settings
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      last_q     <= last_grp;
      extract_q  <= is_extract_i;
      ext_hit_q  <= ext_hit;
      ext_lane_q <= LaneW'(scalar_i % NrLanes);
      vl_q       <= vl_i;
    end
  end

  for (genvar l = 0; l < NrLanes; l++) begin : gen_en
    assign elem_en_o[l] = active_q && (extract_q ?
                          (ext_hit_q && ext_lane_q == LaneW'(l)) :
                          ((int'(grp_q) * NrLanes + l) < int'(vl_q)));
  end

  assign grp_valid_o = active_q;
  assign grp_idx_o   = grp_q;
  assign acc_clear_o = start_i;
  assign done_o      = active_q && (grp_q == last_q);

  // A new command starts only once the previous walk is over
  start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !active_q);

endmodule

//--- verilog/vec_lane.sv
/* One lane's slice of the register file with its element ALU.
   Holds elements lane, lane+NrLanes, ... of every register. No reset on the storage. */

module vec_lane import vec_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned VLEN    = 256,
  localparam int unsigned VLMAX        = VLEN / ElemWidth,
  localparam int unsigned GroupsPerReg = VLMAX / NrLanes,
  localparam int unsigned GrpW         = (GroupsPerReg > 1) ? $clog2(GroupsPerReg) : 1
) (
  input  logic            clk_i,
  input  logic            grp_valid_i,
  input  logic [GrpW-1:0] grp_idx_i,
  input  logic            elem_en_i,
  input  alu_op_e         alu_op_i,
  input  vreg_idx_t       vd_i,
  input  vreg_idx_t       vs1_i,
  input  vreg_idx_t       vs2_i,
  input  elem_t           scalar_i,
  output elem_t           src_elem_o
);

  localparam int unsigned Depth = NrVRegs * GroupsPerReg;
  localparam int unsigned AddrW = $clog2(Depth);

  elem_t            vrf_q [Depth];

  logic [AddrW-1:0] addr_vd;
  logic [AddrW-1:0] addr_vs1;
  logic [AddrW-1:0] addr_vs2;
  elem_t            vs1_elem;
  elem_t            vs2_elem;
  elem_t            alu_res;
  logic             we;

  ////////////////////////////////////////////////////////////
  // Register file access
  ////////////////////////////////////////////////////////////

  // Register-major layout, one row per group
  assign addr_vd  = AddrW'(vd_i * GroupsPerReg + grp_idx_i);
  assign addr_vs1 = AddrW'(vs1_i * GroupsPerReg + grp_idx_i);
  assign addr_vs2 = AddrW'(vs2_i * GroupsPerReg + grp_idx_i);

  assign vs1_elem = vrf_q[addr_vs1];
  assign vs2_elem = vrf_q[addr_vs2];

  // Source element for reductions and extracts
  assign src_elem_o = vs2_elem;

  ////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = vs2_elem + vs1_elem;
      ALU_SUB:  alu_res = vs2_elem - vs1_elem;
      ALU_AND:  alu_res = vs2_elem & vs1_elem;
      ALU_XOR:  alu_res = vs2_elem ^ vs1_elem;
      ALU_ADDX: alu_res = vs2_elem + scalar_i;
      ALU_MOVX: alu_res = scalar_i;
      default:  alu_res = vs2_elem;
    endcase
  end

  // Tail elements never see elem_en, so they keep their value
  assign we = grp_valid_i && elem_en_i && (alu_op_i != ALU_NONE);

  always_ff @(posedge clk_i) begin
    if (we) begin
      vrf_q[addr_vd] <= alu_res;
    end
  end

  // Enables from the sequencer only come inside a group
  en_inside_group: assert property (@(posedge clk_i)
    elem_en_i |-> grp_valid_i);

endmodule

//--- verilog/vec_result.sv
/* Result stage. Sums enabled source elements modulo 2^32 on top of the init value.
   acc_o already includes the group in flight, so it is final in the done cycle. */

module vec_result import vec_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      acc_clear_i,
  input  elem_t                     acc_init_i,
  input  logic                      grp_valid_i,
  input  logic         [NrLanes-1:0] elem_en_i,
  input  elem_t        [NrLanes-1:0] src_elem_i,
  output elem_t                     acc_o
);

  elem_t acc_q;
  elem_t grp_sum;

  // Sum over the enabled lanes of this group
  always_comb begin
    grp_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      if (elem_en_i[l]) begin
        grp_sum = grp_sum + src_elem_i[l];
      end
    end
  end

  assign acc_o = grp_valid_i ? (acc_q + grp_sum) : acc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (acc_clear_i) begin
      acc_q <= acc_init_i;
    end else if (grp_valid_i) begin
      acc_q <= acc_o;
    end
  end

endmodule

//--- verilog/vec_top.sv
/* Vector coprocessor top level with a four-phase req/ack host port.
   NrLanes must be a power of two and VLEN a multiple of 32*NrLanes. */

module vec_top import vec_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned VLEN    = 256
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      cmd_req_i,
  input  vec_op_e   cmd_op_i,
  input  vreg_idx_t cmd_vd_i,
  input  vreg_idx_t cmd_vs1_i,
  input  vreg_idx_t cmd_vs2_i,
  input  elem_t     cmd_scalar_i,
  output logic      cmd_ack_o,
  output elem_t     resp_data_o,
  output logic      resp_err_o
);

  localparam int unsigned VLMAX        = VLEN / ElemWidth;
  localparam int unsigned GroupsPerReg = VLMAX / NrLanes;
  localparam int unsigned GrpW         = (GroupsPerReg > 1) ? $clog2(GroupsPerReg) : 1;

  // Decode to execute
  logic                      start;
  alu_op_e                   alu_op;
  vreg_idx_t                 vd;
  vreg_idx_t                 vs1;
  vreg_idx_t                 vs2;
  elem_t                     scalar;
  elem_t                     acc_init;
  vl_t                       vl;
  logic                      is_extract;
  logic                      done;
  elem_t                     acc;
  // Execute broadcast
  logic                      grp_valid;
  logic         [GrpW-1:0]    grp_idx;
  logic         [NrLanes-1:0] elem_en;
  logic                      acc_clear;
  elem_t        [NrLanes-1:0] src_elem;

  vec_dispatcher #(.NrLanes(NrLanes), .VLEN(VLEN)) u_dispatcher (
    .clk_i, .rst_n_i,
    .cmd_req_i, .cmd_op_i, .cmd_vd_i, .cmd_vs1_i, .cmd_vs2_i, .cmd_scalar_i,
    .cmd_ack_o, .resp_data_o, .resp_err_o,
    .start_o(start), .alu_op_o(alu_op), .vd_o(vd), .vs1_o(vs1), .vs2_o(vs2),
    .scalar_o(scalar), .acc_init_o(acc_init), .vl_o(vl), .is_extract_o(is_extract),
    .done_i(done), .acc_i(acc)
  );

  vec_sequencer #(.NrLanes(NrLanes), .VLEN(VLEN)) u_sequencer (
    .clk_i, .rst_n_i,
    .start_i(start), .vl_i(vl), .is_extract_i(is_extract), .scalar_i(scalar),
    .grp_valid_o(grp_valid), .grp_idx_o(grp_idx), .elem_en_o(elem_en),
    .acc_clear_o(acc_clear), .done_o(done)
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(.NrLanes(NrLanes), .VLEN(VLEN)) u_lane (
      .clk_i, .grp_valid_i(grp_valid), .grp_idx_i(grp_idx), .elem_en_i(elem_en[l]),
      .alu_op_i(alu_op), .vd_i(vd), .vs1_i(vs1), .vs2_i(vs2), .scalar_i(scalar),
      .src_elem_o(src_elem[l])
    );
  end

  vec_result #(.NrLanes(NrLanes)) u_result (
    .clk_i, .rst_n_i,
    .acc_clear_i(acc_clear), .acc_init_i(acc_init), .grp_valid_i(grp_valid),
    .elem_en_i(elem_en), .src_elem_i(src_elem), .acc_o(acc)
  );

  ////////////////////////////////////////////////////////////
  // Parameter checks
  ////////////////////////////////////////////////////////////

  if (NrLanes == 0 || (NrLanes & (NrLanes - 1)) != 0) begin : gen_bad_lanes
    $error("NrLanes must be a nonzero power of two");
  end

  if (VLEN == 0 || (VLEN % (ElemWidth * NrLanes)) != 0) begin : gen_bad_vlen
    $error("VLEN must be a nonzero multiple of 32*NrLanes");
  end

endmodule

//--- tests/tb_clk_gen.sv
/* Free-running clock and a synchronous active-low reset.
   Reset is released with a non-blocking update after ResetCycles rising edges. */

module tb_clk_gen #(
  parameter int unsigned Period      = 10,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- tests/tb_vec_top.sv
/* Table-driven testbench for vec_top. Expected values come from a shadow register file.
   Every register is written before it is read, since the DUT register file has no reset. */

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned NrLanes      = 2;
  localparam int unsigned VLEN         = 256;
  localparam int unsigned VLMAX        = VLEN / ElemWidth;
  localparam int unsigned GroupsPerReg = VLMAX / NrLanes;
  localparam int unsigned ResetCycles  = 16;

  typedef struct {
    logic [3:0] op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elem_t      scalar;
    elem_t      exp_data;
    logic       exp_err;
    logic       chk_data;
  } entry_t;

  logic      clk;
  logic      rst_n;
  logic      cmd_req;
  vec_op_e   cmd_op;
  vreg_idx_t cmd_vd;
  vreg_idx_t cmd_vs1;
  vreg_idx_t cmd_vs2;
  elem_t     cmd_scalar;
  logic      cmd_ack;
  elem_t     resp_data;
  logic      resp_err;

  entry_t      cmd_tbl [$];
  logic        tbl_built = 1'b0;
  // Shadow register file, indexed by register, lane and group
  elem_t       shadow_vrf [NrVRegs][NrLanes][GroupsPerReg];
  int unsigned model_vl = 0;

  tb_clk_gen #(.Period(10), .ResetCycles(ResetCycles)) u_clk_gen (
    .clk_o(clk), .rst_n_o(rst_n)
  );

  vec_top #(.NrLanes(NrLanes), .VLEN(VLEN)) u_dut (
    .clk_i(clk), .rst_n_i(rst_n),
    .cmd_req_i(cmd_req), .cmd_op_i(cmd_op), .cmd_vd_i(cmd_vd), .cmd_vs1_i(cmd_vs1),
    .cmd_vs2_i(cmd_vs2), .cmd_scalar_i(cmd_scalar),
    .cmd_ack_o(cmd_ack), .resp_data_o(resp_data), .resp_err_o(resp_err)
  );

  ////////////////////////////////////////////////////////////
  // Shadow model
  ////////////////////////////////////////////////////////////

  // Element i sits in lane i mod NrLanes, group i / NrLanes
  function automatic elem_t get_elem(input vreg_idx_t r, input int unsigned i);
    return shadow_vrf[r][i % NrLanes][i / NrLanes];
  endfunction

  function automatic void set_elem(input vreg_idx_t r, input int unsigned i, input elem_t v);
    shadow_vrf[r][i % NrLanes][i / NrLanes] = v;
  endfunction

  function automatic elem_t lane_result(input logic [3:0] op, input elem_t a, input elem_t b,
                                        input elem_t x);
    case (op)
      OP_VADD_VV: return a + b;
      OP_VSUB_VV: return a - b;
      OP_VAND_VV: return a & b;
      OP_VXOR_VV: return a ^ b;
      OP_VADD_VX: return a + x;
      default:    return x;
    endcase
  endfunction

  // Append one command and update the model with its effect
  function automatic void add_cmd(input logic [3:0] op, input vreg_idx_t vd,
                                  input vreg_idx_t vs1, input vreg_idx_t vs2,
                                  input elem_t scalar);
    entry_t e;
    e.op       = op;
    e.vd       = vd;
    e.vs1      = vs1;
    e.vs2      = vs2;
    e.scalar   = scalar;
    e.exp_data = '0;
    e.exp_err  = 1'b0;
    e.chk_data = 1'b1;
    case (op)
      OP_SETVL: begin
        model_vl   = (scalar > VLMAX) ? VLMAX : int'(scalar);
        e.exp_data = elem_t'(model_vl);
      end
      OP_VADD_VV, OP_VSUB_VV, OP_VAND_VV, OP_VXOR_VV, OP_VADD_VX, OP_VMV_VX: begin
        for (int unsigned i = 0; i < model_vl; i++) begin
          set_elem(vd, i, lane_result(op, get_elem(vs2, i), get_elem(vs1, i), scalar));
        end
      end
      OP_REDSUM: begin
        e.exp_data = scalar;
        for (int unsigned i = 0; i < model_vl; i++) begin
          e.exp_data = e.exp_data + get_elem(vs2, i);
        end
      end
      OP_EXTRACT: e.exp_data = (scalar < VLMAX) ? get_elem(vs2, int'(scalar)) : '0;
      // Response data of a rejected command is left unchecked
      default: begin
        e.exp_err  = 1'b1;
        e.chk_data = 1'b0;
      end
    endcase
    cmd_tbl.push_back(e);
  endfunction

  function automatic void set_vl(input int unsigned n);
    add_cmd(OP_SETVL, '0, '0, '0, elem_t'(n));
  endfunction

  function automatic void read_back(input vreg_idx_t r);
    for (int unsigned i = 0; i < VLMAX; i++) begin
      add_cmd(OP_EXTRACT, '0, '0, r, elem_t'(i));
    end
  endfunction

  function automatic vreg_idx_t rand_reg();
    return vreg_idx_t'($urandom_range(NrVRegs - 1, 0));
  endfunction

  function automatic void build_table();
    vreg_idx_t vd;
    // Length setting, including zero and above VLMAX
    set_vl(0);
    set_vl(20);
    set_vl(5);
    set_vl(VLMAX);
    // Fill every register, then vary the leading elements
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      add_cmd(OP_VMV_VX, vreg_idx_t'(r), '0, '0, $urandom);
    end
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      set_vl((r % (VLMAX - 1)) + 1);
      add_cmd(OP_VADD_VX, vreg_idx_t'(r), '0, vreg_idx_t'(r), $urandom);
    end
    set_vl(VLMAX);
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      read_back(vreg_idx_t'(r));
    end
    // One of each element-wise op, then random ones
    add_cmd(OP_VADD_VV, 3'd0, 3'd1, 3'd2, '0);
    read_back(3'd0);
    add_cmd(OP_VSUB_VV, 3'd3, 3'd4, 3'd5, '0);
    read_back(3'd3);
    add_cmd(OP_VAND_VV, 3'd6, 3'd7, 3'd1, '0);
    read_back(3'd6);
    add_cmd(OP_VXOR_VV, 3'd2, 3'd3, 3'd0, '0);
    read_back(3'd2);
    add_cmd(OP_VADD_VX, 3'd5, '0, 3'd6, $urandom);
    read_back(3'd5);
    for (int k = 0; k < 6; k++) begin
      vd = rand_reg();
      add_cmd(4'($urandom_range(6, 1)), vd, rand_reg(), rand_reg(), $urandom);
      read_back(vd);
    end
    // Tail elements stay as they were
    set_vl(5);
    add_cmd(OP_VADD_VV, 3'd1, 3'd2, 3'd3, '0);
    read_back(3'd1);
    set_vl(3);
    add_cmd(OP_VMV_VX, 3'd7, '0, '0, $urandom);
    read_back(3'd7);
    // Reductions at full, partial and zero length
    set_vl(VLMAX);
    add_cmd(OP_REDSUM, '0, '0, 3'd1, $urandom);
    set_vl(6);
    add_cmd(OP_REDSUM, '0, '0, 3'd2, $urandom);
    set_vl(0);
    add_cmd(OP_REDSUM, '0, '0, 3'd3, $urandom);
    add_cmd(OP_VADD_VV, 3'd0, 3'd4, 3'd5, '0);
    read_back(3'd0);
    // Extract past the end of the register
    set_vl(VLMAX);
    add_cmd(OP_EXTRACT, '0, '0, 3'd1, elem_t'(VLMAX));
    add_cmd(OP_EXTRACT, '0, '0, 3'd1, 32'd200);
    add_cmd(OP_EXTRACT, '0, '0, 3'd1, 32'hffff_ffff);
    // Rejected opcodes must not touch vl or any register
    set_vl(4);
    for (int unsigned c = 9; c < 16; c++) begin
      add_cmd(4'(c), rand_reg(), rand_reg(), rand_reg(), 32'd2);
    end
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      read_back(vreg_idx_t'(r));
    end
    add_cmd(OP_REDSUM, '0, '0, 3'd0, '0);
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and stimulus
  ////////////////////////////////////////////////////////////

  task automatic check_data(input int idx, input string name, input elem_t got,
                            input elem_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s (entry %0d) is %h, expected %h", $time, name, idx,
               got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_err(input int idx, input string name, input logic got,
                           input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s (entry %0d) is %b, expected %b", $time, name, idx,
               got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // Four-phase handshake for one table entry
  task automatic apply_entry(input int idx);
    entry_t e;
    e = cmd_tbl[idx];
    @(posedge clk);
    cmd_op     <= vec_op_e'(e.op);
    cmd_vd     <= e.vd;
    cmd_vs1    <= e.vs1;
    cmd_vs2    <= e.vs2;
    cmd_scalar <= e.scalar;
    cmd_req    <= 1'b1;
    @(posedge clk);
    while (!cmd_ack) @(posedge clk);
    if (e.chk_data) begin
      check_data(idx, "resp_data_o", resp_data, e.exp_data);
    end
    check_err(idx, "resp_err_o", resp_err, e.exp_err);
    cmd_req <= 1'b0;
    @(posedge clk);
    while (cmd_ack) @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'hbbae));
    cmd_req    = 1'b0;
    cmd_op     = OP_SETVL;
    cmd_vd     = '0;
    cmd_vs1    = '0;
    cmd_vs2    = '0;
    cmd_scalar = '0;
    build_table();
    tbl_built = 1'b1;
    wait (rst_n === 1'b1);
    for (int i = 0; i < cmd_tbl.size(); i++) begin
      apply_entry(i);
    end
    $display("All tests passed");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int unsigned limit;
    wait (tbl_built);
    limit = cmd_tbl.size() * (GroupsPerReg + 10) * 2 + ResetCycles;
    repeat (limit) @(posedge clk);
    $display("Timeout: the DUT did not finish all commands within %0d cycles", limit);
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

//--- src.f
verilog/vec_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_result.sv
verilog/vec_top.sv
tests/tb_clk_gen.sv
tests/tb_vec_top.sv
